//--- hdl/rms_norm_pkg.sv
// Shared dimensions, fixed-point formats and types of the RMS-norm stream block, imported by each stage
`default_nettype none

package rms_norm_pkg;

    // Tensor shape and beat layout
    localparam int LANES      = 4;
    localparam int TOTAL_DIM0 = 4;
    localparam int TOTAL_DIM1 = 4;
    localparam int CHANNELS   = 2;
    localparam int NUM_VALUES = TOTAL_DIM0 * TOTAL_DIM1 * CHANNELS;
    localparam int NUM_ITERS  = NUM_VALUES / LANES;
    localparam int ITER_WIDTH = $clog2(NUM_ITERS);
    // NUM_VALUES is a power of two, so the mean is a shift
    localparam int MEAN_SHIFT = $clog2(NUM_VALUES);

    // Signed fixed-point formats at the ports
    localparam int IN_WIDTH         = 8;
    localparam int IN_FRAC_WIDTH    = 2;
    localparam int SCALE_WIDTH      = 8;
    localparam int SCALE_FRAC_WIDTH = 2;
    localparam int OUT_WIDTH        = 8;
    localparam int OUT_FRAC_WIDTH   = 4;

    // Internal widths
    localparam int SQUARE_WIDTH      = 2 * IN_WIDTH;
    localparam int ACC_WIDTH         = SQUARE_WIDTH + $clog2(LANES) + ITER_WIDTH;
    localparam int ACC_FRAC_WIDTH    = 2 * IN_FRAC_WIDTH;
    localparam int ISQRT_WIDTH       = 16;
    localparam int ISQRT_FRAC_WIDTH  = 12;
    localparam int ISQRT_NUM_SHIFT   = 2 * ISQRT_FRAC_WIDTH + ACC_FRAC_WIDTH;
    localparam int NORM_WIDTH        = IN_WIDTH + ISQRT_WIDTH + 1;
    localparam int AFFINE_WIDTH      = NORM_WIDTH + SCALE_WIDTH;
    localparam int AFFINE_FRAC_WIDTH = IN_FRAC_WIDTH + ISQRT_FRAC_WIDTH + SCALE_FRAC_WIDTH;
    localparam int OUT_SHIFT         = AFFINE_FRAC_WIDTH - OUT_FRAC_WIDTH;

    // Bit-serial inverse root step counts
    localparam int DIV_STEPS  = ISQRT_NUM_SHIFT + 1;
    localparam int ROOT_STEPS = (ISQRT_NUM_SHIFT + 2) / 2;
    localparam int STEP_WIDTH = $clog2(DIV_STEPS);

    typedef logic [IN_WIDTH-1:0]            in_t;
    typedef logic [SCALE_WIDTH-1:0]         scale_t;
    typedef logic [OUT_WIDTH-1:0]           out_t;
    typedef logic [ACC_WIDTH-1:0]           acc_t;
    typedef logic [ISQRT_WIDTH-1:0]         isqrt_t;
    typedef logic signed [NORM_WIDTH-1:0]   norm_t;
    typedef logic signed [AFFINE_WIDTH-1:0] affine_t;

    typedef in_t    lane_in_t    [LANES];
    typedef scale_t lane_scale_t [LANES];
    typedef out_t   lane_out_t   [LANES];

    typedef enum logic [1:0] {IDLE, DIVIDE, ROOT, HOLD} isqrt_state_t;

endpackage

`default_nettype wire

//--- hdl/sample_fifo.sv
// Beat buffer that keeps input samples until the inverse root of their vector is ready
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
    parameter int DEPTH = 16
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  push,
    input  rms_norm_pkg::lane_in_t     push_data,
    output logic                       full,
    output rms_norm_pkg::lane_in_t     fifo_data,
    output logic                       fifo_valid,
    input  wire logic                  fifo_ready
);
    import rms_norm_pkg::*;

    localparam int PTR_WIDTH = $clog2(DEPTH);
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    lane_in_t mem [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic wr_en;
    logic rd_en;

    assign full       = (count == CNT_WIDTH'(DEPTH));
    assign fifo_valid = (count != '0);
    assign fifo_data  = mem[rd_ptr];

    // A push while full is dropped
    assign wr_en = push && !full;
    assign rd_en = fifo_valid && fifo_ready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/sum_squares.sv
// Sum of squares over one vector, divided down to the mean square and handed on as a stream
`timescale 1ns/1ps
`default_nettype none

module sum_squares (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              beat,
    input  rms_norm_pkg::lane_in_t beat_data,
    output logic                   busy,
    output rms_norm_pkg::acc_t     mean_sq,
    output logic                   mean_valid,
    input  wire logic              mean_ready
);
    import rms_norm_pkg::*;

    logic signed [SQUARE_WIDTH-1:0] square [LANES];
    acc_t beat_sum_c;
    acc_t beat_sum;
    logic sum_valid;
    acc_t acc;
    acc_t acc_next;
    logic [ITER_WIDTH-1:0] beat_cnt;
    logic last;
    logic stall;
    logic acc_take;

    // Squares are never negative, so they add as unsigned values
    always_comb begin
        beat_sum_c = '0;
        for (int i = 0; i < LANES; i++) begin
            square[i]  = $signed(beat_data[i]) * $signed(beat_data[i]);
            beat_sum_c = beat_sum_c + {{(ACC_WIDTH-SQUARE_WIDTH){1'b0}}, square[i]};
        end
    end

    assign last     = (beat_cnt == ITER_WIDTH'(NUM_ITERS - 1));
    assign acc_next = acc + beat_sum;

    // Closing a vector needs the mean register free
    assign stall    = last && mean_valid && !mean_ready;
    assign acc_take = sum_valid && !stall;

    // Conservative, keeps mean_ready out of the input path
    assign busy = sum_valid && last && mean_valid;

    // Beat sum register
    always_ff @(posedge clk) begin
        if (beat) begin
            beat_sum <= beat_sum_c;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
        end else if (beat) begin
            sum_valid <= 1'b1;
        end else if (acc_take) begin
            sum_valid <= 1'b0;
        end
    end

    // Accumulator, beat counter and mean output register
    always_ff @(posedge clk) begin
        if (rst) begin
            acc        <= '0;
            beat_cnt   <= '0;
            mean_valid <= 1'b0;
        end else begin
            if (mean_valid && mean_ready) begin
                mean_valid <= 1'b0;
            end
            if (acc_take) begin
                if (last) begin
                    acc        <= '0;
                    beat_cnt   <= '0;
                    mean_valid <= 1'b1;
                end else begin
                    acc      <= acc_next;
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acc_take && last) begin
            mean_sq <= acc_next >> MEAN_SHIFT;
        end
    end

endmodule

`default_nettype wire

//--- hdl/isqrt_recip.sv
// Exact fixed-point inverse square root of the mean square by serial division and serial root
`timescale 1ns/1ps
`default_nettype none

module isqrt_recip (
    input  wire logic            clk,
    input  wire logic            rst,
    input  rms_norm_pkg::acc_t   mean_sq,
    input  wire logic            mean_valid,
    output logic                 mean_ready,
    output rms_norm_pkg::isqrt_t recip,
    output logic                 recip_valid,
    input  wire logic            recip_ready
);
    import rms_norm_pkg::*;

    isqrt_state_t state;
    logic [STEP_WIDTH-1:0] step_cnt;
    acc_t divisor;
    // Shared remainder for division and root
    logic [ACC_WIDTH:0] rem;
    // Numerator bits shift out while quotient bits shift in, top bit pads the root to pairs
    logic [ISQRT_NUM_SHIFT+1:0] work;
    isqrt_t root;

    logic [ACC_WIDTH:0] div_trial;
    logic [ACC_WIDTH:0] div_rem;
    logic div_ge;
    logic [ISQRT_WIDTH+3:0] root_trial;
    logic [ISQRT_WIDTH+3:0] root_sub;
    logic [ISQRT_WIDTH+3:0] root_rem;
    logic root_ge;

    // One restoring division step
    assign div_trial = {rem[ACC_WIDTH-1:0], work[ISQRT_NUM_SHIFT]};
    assign div_ge    = (div_trial >= {1'b0, divisor});
    assign div_rem   = div_ge ? div_trial - {1'b0, divisor} : div_trial;

    // One digit-by-digit root step, two radicand bits per cycle
    assign root_trial = {rem[ISQRT_WIDTH+1:0], work[ISQRT_NUM_SHIFT+1:ISQRT_NUM_SHIFT]};
    assign root_sub   = {2'b00, root, 2'b01};
    assign root_ge    = (root_trial >= root_sub);
    assign root_rem   = root_ge ? root_trial - root_sub : root_trial;

    assign mean_ready  = (state == IDLE);
    assign recip_valid = (state == HOLD);
    // Zero mean saturates to the largest inverse root
    assign recip = (divisor == '0) ? '1 : root;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            step_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (mean_valid) begin
                        state    <= DIVIDE;
                        step_cnt <= '0;
                    end
                end
                DIVIDE: begin
                    if (step_cnt == STEP_WIDTH'(DIV_STEPS - 1)) begin
                        state    <= ROOT;
                        step_cnt <= '0;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                ROOT: begin
                    if (step_cnt == STEP_WIDTH'(ROOT_STEPS - 1)) begin
                        state <= HOLD;
                    end else begin
                        step_cnt <= step_cnt + 1'b1;
                    end
                end
                HOLD: begin
                    if (recip_ready) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        case (state)
            IDLE: begin
                if (mean_valid) begin
                    divisor <= mean_sq;
                    rem     <= '0;
                    work    <= {2'b01, {ISQRT_NUM_SHIFT{1'b0}}};
                end
            end
            DIVIDE: begin
                work <= {1'b0, work[ISQRT_NUM_SHIFT-1:0], div_ge};
                if (step_cnt == STEP_WIDTH'(DIV_STEPS - 1)) begin
                    rem  <= '0;
                    root <= '0;
                end else begin
                    rem <= div_rem;
                end
            end
            ROOT: begin
                work <= {work[ISQRT_NUM_SHIFT-1:0], 2'b00};
                rem  <= {{(ACC_WIDTH-ISQRT_WIDTH-3){1'b0}}, root_rem};
                root <= {root[ISQRT_WIDTH-2:0], root_ge};
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/scale_stage.sv
// Normalize and weight each buffered beat, then floor and saturate it to the output format
`timescale 1ns/1ps
`default_nettype none

module scale_stage (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  rms_norm_pkg::isqrt_t      recip,
    input  wire logic                 recip_valid,
    output logic                      recip_ready,
    input  rms_norm_pkg::lane_in_t    fifo_data,
    input  wire logic                 fifo_valid,
    output logic                      fifo_ready,
    input  rms_norm_pkg::lane_scale_t weight_data,
    input  wire logic                 weight_valid,
    output logic                      weight_ready,
    output rms_norm_pkg::lane_out_t   out_data,
    output logic                      out_valid,
    input  wire logic                 out_ready
);
    import rms_norm_pkg::*;

    // Arithmetic shift floors, then clip when upper bits disagree with the sign
    function automatic out_t sat_cast(input affine_t value);
        affine_t shifted;
        shifted = value >>> OUT_SHIFT;
        if (!shifted[AFFINE_WIDTH-1] && (shifted[AFFINE_WIDTH-2:OUT_WIDTH-1] != '0)) begin
            return {1'b0, {(OUT_WIDTH-1){1'b1}}};
        end else if (shifted[AFFINE_WIDTH-1] && (shifted[AFFINE_WIDTH-2:OUT_WIDTH-1] != '1)) begin
            return {1'b1, {(OUT_WIDTH-1){1'b0}}};
        end
        return shifted[OUT_WIDTH-1:0];
    endfunction

    isqrt_t rec_hold;
    logic rec_held;
    logic [ITER_WIDTH-1:0] beat_cnt;

    norm_t norm_c [LANES];
    norm_t s1_data [LANES];
    logic s1_valid;
    logic s1_fire;
    logic s2_take;
    logic s2_open;

    // Slot is free when empty or drained this cycle
    assign s2_open = !out_valid || out_ready;
    assign s2_take = s1_valid && weight_valid && s2_open;
    assign s1_fire = fifo_valid && rec_held && (!s1_valid || s2_take);

    assign recip_ready  = !rec_held;
    assign fifo_ready   = rec_held && (!s1_valid || s2_take);
    assign weight_ready = s1_valid && s2_open;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            norm_c[i] = $signed(fifo_data[i]) * $signed({1'b0, rec_hold});
        end
    end

    // Hold one inverse root for a whole vector
    always_ff @(posedge clk) begin
        if (rst) begin
            rec_held <= 1'b0;
            beat_cnt <= '0;
        end else if (recip_valid && recip_ready) begin
            rec_held <= 1'b1;
        end else if (s1_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == ITER_WIDTH'(NUM_ITERS - 1)) begin
                rec_held <= 1'b0;
                beat_cnt <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (recip_valid && recip_ready) begin
            rec_hold <= recip;
        end
    end

    // Valid flags of both stages
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (s1_fire) begin
                s1_valid <= 1'b1;
            end else if (s2_take) begin
                s1_valid <= 1'b0;
            end
            if (s2_take) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (s1_fire) begin
                s1_data[i] <= norm_c[i];
            end
            if (s2_take) begin
                out_data[i] <= sat_cast($signed(s1_data[i]) * $signed(weight_data[i]));
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/rms_norm_2d.sv
// Top level of the streaming RMS-norm block, forks input beats to the buffer and the sum path
`timescale 1ns/1ps
`default_nettype none

module rms_norm_2d (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  rms_norm_pkg::lane_in_t    in_data,
    input  wire logic                 in_valid,
    output logic                      in_ready,
    input  rms_norm_pkg::lane_scale_t weight_data,
    input  wire logic                 weight_valid,
    output logic                      weight_ready,
    output rms_norm_pkg::lane_out_t   out_data,
    output logic                      out_valid,
    input  wire logic                 out_ready
);
    import rms_norm_pkg::*;

    logic accept;
    logic fifo_full;
    logic sq_busy;

    lane_in_t fifo_data;
    logic fifo_valid;
    logic fifo_ready;

    acc_t mean_sq;
    logic mean_valid;
    logic mean_ready;

    isqrt_t recip;
    logic recip_valid;
    logic recip_ready;

    // Fork, a beat enters only when buffer and sum path both take it
    assign in_ready = !fifo_full && !sq_busy;
    assign accept   = in_valid && in_ready;

    sample_fifo #(
        .DEPTH      (2 * NUM_ITERS)
    ) fifo0 (
        .clk        (clk),
        .rst        (rst),
        .push       (accept),
        .push_data  (in_data),
        .full       (fifo_full),
        .fifo_data  (fifo_data),
        .fifo_valid (fifo_valid),
        .fifo_ready (fifo_ready)
    );

    sum_squares sq0 (
        .clk        (clk),
        .rst        (rst),
        .beat       (accept),
        .beat_data  (in_data),
        .busy       (sq_busy),
        .mean_sq    (mean_sq),
        .mean_valid (mean_valid),
        .mean_ready (mean_ready)
    );

    isqrt_recip isq0 (
        .clk         (clk),
        .rst         (rst),
        .mean_sq     (mean_sq),
        .mean_valid  (mean_valid),
        .mean_ready  (mean_ready),
        .recip       (recip),
        .recip_valid (recip_valid),
        .recip_ready (recip_ready)
    );

    scale_stage scl0 (
        .clk          (clk),
        .rst          (rst),
        .recip        (recip),
        .recip_valid  (recip_valid),
        .recip_ready  (recip_ready),
        .fifo_data    (fifo_data),
        .fifo_valid   (fifo_valid),
        .fifo_ready   (fifo_ready),
        .weight_data  (weight_data),
        .weight_valid (weight_valid),
        .weight_ready (weight_ready),
        .out_data     (out_data),
        .out_valid    (out_valid),
        .out_ready    (out_ready)
    );

endmodule

`default_nettype wire

//--- verif/rms_norm_checker.sv
// Reference model of the RMS-norm block, watches the stream handshakes and checks every output beat
`timescale 1ns/1ps
`default_nettype none

module rms_norm_checker (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  rms_norm_pkg::lane_in_t    in_data,
    input  wire logic                 in_valid,
    input  wire logic                 in_ready,
    input  rms_norm_pkg::lane_scale_t weight_data,
    input  wire logic                 weight_valid,
    input  wire logic                 weight_ready,
    input  rms_norm_pkg::lane_out_t   out_data,
    input  wire logic                 out_valid,
    input  wire logic                 out_ready
);
    import rms_norm_pkg::*;

    // Product carries 2 + 12 + 2 fraction bits, output keeps 4
    localparam int FLOOR_SHIFT = IN_FRAC_WIDTH + ISQRT_FRAC_WIDTH + SCALE_FRAC_WIDTH
                                 - OUT_FRAC_WIDTH;
    localparam longint OUT_MAX = 2**(OUT_WIDTH-1) - 1;
    localparam longint OUT_MIN = -(2**(OUT_WIDTH-1));

    int error_count = 0;
    int beats_checked = 0;
    int pending_beats = 0;
    logic [31:0] vec_beats [$];
    logic [31:0] pend_data [$];
    int pend_recip [$];
    logic [31:0] weight_q [$];

    // Largest r with r*r*mean <= 2^28, which is floor(2^14 / sqrt(mean))
    function automatic int inv_root(input longint mean);
        longint r;
        longint t;
        if (mean == 0) begin
            return (1 << ISQRT_WIDTH) - 1;
        end
        r = 0;
        for (int b = ISQRT_WIDTH - 1; b >= 0; b--) begin
            t = r | (longint'(1) << b);
            if (t * t * mean <= (longint'(1) << ISQRT_NUM_SHIFT)) begin
                r = t;
            end
        end
        return int'(r);
    endfunction

    function automatic out_t model_lane(input in_t x, input int r, input scale_t w);
        longint prod;
        prod = longint'($signed(x)) * longint'(r) * longint'($signed(w));
        // Arithmetic shift of a signed value rounds toward minus infinity
        prod = prod >>> FLOOR_SHIFT;
        if (prod > OUT_MAX) begin
            return out_t'(OUT_MAX);
        end else if (prod < OUT_MIN) begin
            return out_t'(OUT_MIN);
        end
        return out_t'(prod);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic take_input();
        logic [31:0] word;
        longint sum_sq;
        longint x;
        int r;
        for (int i = 0; i < LANES; i++) begin
            word[8*i +: 8] = in_data[i];
        end
        vec_beats.push_back(word);
        if (vec_beats.size() == NUM_ITERS) begin
            sum_sq = 0;
            foreach (vec_beats[b]) begin
                for (int i = 0; i < LANES; i++) begin
                    x = $signed(vec_beats[b][8*i +: 8]);
                    sum_sq += x * x;
                end
            end
            r = inv_root(sum_sq >> MEAN_SHIFT);
            while (vec_beats.size() != 0) begin
                pend_data.push_back(vec_beats.pop_front());
                pend_recip.push_back(r);
            end
        end
    endtask

    task automatic take_weight();
        logic [31:0] word;
        for (int i = 0; i < LANES; i++) begin
            word[8*i +: 8] = weight_data[i];
        end
        weight_q.push_back(word);
    endtask

    task automatic compare_output();
        logic [31:0] beat_word;
        logic [31:0] w_word;
        int r;
        out_t expv;
        if (pend_data.size() == 0 || weight_q.size() == 0) begin
            $display("[ERROR] output beat %0d accepted with no finished input or weight for it",
                     beats_checked);
            error_count++;
        end else begin
            beat_word = pend_data.pop_front();
            r = pend_recip.pop_front();
            w_word = weight_q.pop_front();
            for (int i = 0; i < LANES; i++) begin
                expv = model_lane(beat_word[8*i +: 8], r, w_word[8*i +: 8]);
                if (out_data[i] !== expv) begin
                    $display("[FAIL] out_data[%0d] beat %0d: got %h expected %h",
                             i, beats_checked, out_data[i], expv);
                    error_count++;
                end
            end
        end
        beats_checked <= beats_checked + 1;
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            if (out_valid && out_ready) begin
                compare_output();
            end
            if (in_valid && in_ready) begin
                take_input();
            end
            if (weight_valid && weight_ready) begin
                take_weight();
            end
            pending_beats <= pend_data.size() + vec_beats.size();
        end
    end

endmodule

`default_nettype wire

//--- verif/rms_norm_tb.sv
// Testbench for the RMS-norm block, drives LCG streams with back-pressure and prints the result
`timescale 1ns/1ps
`default_nettype none

module rms_norm_tb;
    import rms_norm_pkg::*;

    localparam int TOTAL_VECTORS   = 20 + 4 + 4 + 10 + 12;
    localparam int WATCHDOG_CYCLES = TOTAL_VECTORS * NUM_ITERS * 200;

    logic clk;
    logic rst;
    lane_in_t in_data;
    logic in_valid;
    logic in_ready;
    lane_scale_t weight_data;
    logic weight_valid;
    logic weight_ready;
    lane_out_t out_data;
    logic out_valid;
    logic out_ready;

    logic [31:0] seed;
    logic [31:0] in_q [$];
    logic [31:0] w_q [$];
    int test_count;
    int err_mark;
    int beat_mark;

    rms_norm_2d dut0 (
        .clk(clk), .rst(rst),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .weight_data(weight_data), .weight_valid(weight_valid), .weight_ready(weight_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
    );

    rms_norm_checker chk0 (
        .clk(clk), .rst(rst),
        .in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
        .weight_data(weight_data), .weight_valid(weight_valid), .weight_ready(weight_ready),
        .out_data(out_data), .out_valid(out_valid), .out_ready(out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Low LCG bits repeat quickly, fold the upper half in
    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed ^ (seed >> 16);
    endfunction

    function automatic logic chance(input int pct);
        return ((next_rand() >> 16) % 100) < pct;
    endfunction

    task automatic queue_random(input int count);
        repeat (count * NUM_ITERS) begin
            in_q.push_back(next_rand());
            w_q.push_back(next_rand());
        end
    endtask

    task automatic queue_fill(input logic [7:0] value);
        repeat (NUM_ITERS) begin
            in_q.push_back({LANES{value}});
            w_q.push_back(next_rand());
        end
    endtask

    // One nonzero lane in the first beat, so the mean square floors to zero
    task automatic queue_sparse(input logic [7:0] value);
        in_q.push_back({24'h0, value});
        w_q.push_back(next_rand());
        repeat (NUM_ITERS - 1) begin
            in_q.push_back('0);
            w_q.push_back(next_rand());
        end
    endtask

    // Magnitudes of 96 and up against weights of +31.75 or -32
    task automatic queue_large(input int count);
        logic [31:0] word;
        logic [31:0] wword;
        logic [7:0] mag;
        repeat (count * NUM_ITERS) begin
            for (int i = 0; i < LANES; i++) begin
                mag = 8'd96 + 8'(next_rand() % 32);
                word[8*i +: 8] = chance(50) ? -mag : mag;
                wword[8*i +: 8] = chance(50) ? 8'h7F : 8'h80;
            end
            in_q.push_back(word);
            w_q.push_back(wword);
        end
    endtask

    // Streams the queued beats until every one has come out
    task automatic run_stream(input int in_gap, input int w_gap, input int ready_low);
        int target;
        target = chk0.beats_checked + in_q.size();
        while (chk0.beats_checked < target) begin
            @(posedge clk);
            if (in_valid && in_ready) begin
                void'(in_q.pop_front());
            end
            if (in_ready || !in_valid) begin
                if (in_q.size() != 0 && !chance(in_gap)) begin
                    in_valid <= 1'b1;
                    for (int i = 0; i < LANES; i++) begin
                        in_data[i] <= in_q[0][8*i +: 8];
                    end
                end else begin
                    in_valid <= 1'b0;
                end
            end
            if (weight_valid && weight_ready) begin
                void'(w_q.pop_front());
            end
            if (weight_ready || !weight_valid) begin
                if (w_q.size() != 0 && !chance(w_gap)) begin
                    weight_valid <= 1'b1;
                    for (int i = 0; i < LANES; i++) begin
                        weight_data[i] <= w_q[0][8*i +: 8];
                    end
                end else begin
                    weight_valid <= 1'b0;
                end
            end
            out_ready <= !chance(ready_low);
        end
    endtask

    task automatic end_test(input string name);
        test_count++;
        $display("test %0d %s: %0d beats checked, %0d errors", test_count, name,
                 chk0.beats_checked - beat_mark, chk0.error_count - err_mark);
        err_mark = chk0.error_count;
        beat_mark = chk0.beats_checked;
    endtask

    initial begin
        seed = 32'h313c_f129;
        rst = 1'b1;
        in_valid = 1'b0;
        weight_valid = 1'b0;
        out_ready = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            in_data[i] = '0;
            weight_data[i] = '0;
        end
        test_count = 0;
        err_mark = 0;
        beat_mark = 0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        repeat (5) begin
            @(posedge clk);
            chk0.check_value("out_valid", out_valid, 0);
        end
        chk0.check_value("in_ready", in_ready, 1);
        end_test("idle after reset");

        queue_random(20);
        run_stream(25, 0, 0);
        end_test("random vectors");

        // Zero vector, a lone 0.5 whose mean floors to zero, then constant 0.25 and -0.75
        queue_fill(8'h00);
        queue_sparse(8'h02);
        queue_fill(8'h01);
        queue_fill(8'hFD);
        run_stream(0, 0, 0);
        end_test("zero and constant vectors");

        queue_large(4);
        run_stream(10, 0, 0);
        end_test("saturation");

        queue_random(10);
        run_stream(20, 50, 50);
        out_ready <= 1'b1;
        repeat (20) @(posedge clk);
        chk0.check_value("output beat count", chk0.beats_checked - beat_mark, 10 * NUM_ITERS);
        chk0.check_value("pending beats", chk0.pending_beats, 0);
        end_test("output back-pressure");

        queue_random(12);
        run_stream(0, 0, 0);
        repeat (20) @(posedge clk);
        chk0.check_value("output beat count", chk0.beats_checked - beat_mark, 12 * NUM_ITERS);
        end_test("back-to-back vectors");

        $display("tests %0d, beats checked %0d, errors %0d",
                 test_count, chk0.beats_checked, chk0.error_count);
        if (chk0.error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped delivering output",
                 WATCHDOG_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hdl/rms_norm_pkg.sv
hdl/sample_fifo.sv
hdl/sum_squares.sv
hdl/isqrt_recip.sv
hdl/scale_stage.sv
hdl/rms_norm_2d.sv
verif/rms_norm_checker.sv
verif/rms_norm_tb.sv

//--- Bender.yml
package:
  name: rms_norm_2d

sources:
  - files:
      - hdl/rms_norm_pkg.sv
      - hdl/sample_fifo.sv
      - hdl/sum_squares.sv
      - hdl/isqrt_recip.sv
      - hdl/scale_stage.sv
      - hdl/rms_norm_2d.sv
  - target: any(test, simulation)
    files:
      - verif/rms_norm_checker.sv
      - verif/rms_norm_tb.sv

# Simulation top: rms_norm_tb
# Synthesis top: rms_norm_2d
